// File: include/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN      32
`define MIPS_REG_AW    5
`define MIPS_NUM_REGS  32
`define MIPS_RESET_PC  32'hBFC0_0000

// Low bit of each register and shift field in an instruction word
`define MIPS_RS_LSB    21
`define MIPS_RT_LSB    16
`define MIPS_RD_LSB    11
`define MIPS_SA_LSB    6

`endif

// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // SPECIAL funct field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_LUI = 4'd7
    } alu_op_e;

endpackage

// File: src/mips_pipe_pkg.sv
`include "mips_consts.svh"

package mips_pipe_pkg;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   inst;
    } if_id_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        mips_isa_pkg::alu_op_e   alu_op;
        logic [`MIPS_XLEN-1:0]   op_a;
        logic [`MIPS_XLEN-1:0]   op_b;      // Immediate already selected
        logic [`MIPS_XLEN-1:0]   store_data;
        logic                    reg_we;
        logic [`MIPS_REG_AW-1:0] dest;
        logic                    mem_read;
        logic                    mem_write;
    } id_ex_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   alu_result; // Also the data address
        logic [`MIPS_XLEN-1:0]   store_data;
        logic                    reg_we;
        logic [`MIPS_REG_AW-1:0] dest;
        logic                    mem_read;
        logic                    mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic                    reg_we;
        logic [`MIPS_REG_AW-1:0] dest;
        logic [`MIPS_XLEN-1:0]   data;
    } mem_wb_t;

    // In-flight result, also the register file write
    typedef struct packed {
        logic                    we;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   data;
    } fwd_t;

endpackage

// File: src/mips_fetch.sv
`include "mips_consts.svh"

module mips_fetch (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   inst_stall_i,
    input  logic                   data_stall_i,
    input  logic                   load_use_stall_i,
    input  logic                   branch_taken_i,
    input  logic [`MIPS_XLEN-1:0]  branch_target_i,
    input  logic [`MIPS_XLEN-1:0]  inst_rdata_i,
    output logic [`MIPS_XLEN-1:0]  inst_addr_o,
    output mips_pipe_pkg::if_id_t  if_id_o
);

    logic                  hold;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_next;

    assign hold        = inst_stall_i | data_stall_i | load_use_stall_i;
    assign pc_next     = branch_taken_i ? branch_target_i : pc + `MIPS_XLEN'd4;
    assign inst_addr_o = pc;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc      <= `MIPS_RESET_PC;
            if_id_o <= '0;                  // SLL r0 bubble
        end else if (!hold) begin
            pc           <= pc_next;
            if_id_o.pc   <= pc;
            if_id_o.inst <= inst_rdata_i;
        end
    end

endmodule

// File: src/mips_regfile.sv
`include "mips_consts.svh"

module mips_regfile (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`MIPS_REG_AW-1:0] rs_addr_i,
    input  logic [`MIPS_REG_AW-1:0] rt_addr_i,
    output logic [`MIPS_XLEN-1:0]   rs_data_o,
    output logic [`MIPS_XLEN-1:0]   rt_data_o,
    input  mips_pipe_pkg::fwd_t     commit_i
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i.we) begin
            regs[commit_i.addr] <= commit_i.data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    always_comb begin
        if (rs_addr_i == '0)
            rs_data_o = '0;
        else if (commit_i.we && commit_i.addr == rs_addr_i)
            rs_data_o = commit_i.data;
        else
            rs_data_o = regs[rs_addr_i];
        if (rt_addr_i == '0)
            rt_data_o = '0;
        else if (commit_i.we && commit_i.addr == rt_addr_i)
            rt_data_o = commit_i.data;
        else
            rt_data_o = regs[rt_addr_i];
    end

endmodule

// File: src/mips_decode.sv
`include "mips_consts.svh"

module mips_decode (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    inst_stall_i,
    input  logic                    data_stall_i,
    input  mips_pipe_pkg::if_id_t   if_id_i,
    output logic [`MIPS_REG_AW-1:0] rs_addr_o,
    output logic [`MIPS_REG_AW-1:0] rt_addr_o,
    input  logic [`MIPS_XLEN-1:0]   rs_data_i,
    input  logic [`MIPS_XLEN-1:0]   rt_data_i,
    input  mips_pipe_pkg::fwd_t     ex_fwd_i,
    input  logic                    ex_mem_read_i,
    input  mips_pipe_pkg::fwd_t     mem_fwd_i,
    output logic                    load_use_stall_o,
    output logic                    branch_taken_o,
    output logic [`MIPS_XLEN-1:0]   branch_target_o,
    output mips_pipe_pkg::id_ex_t   id_ex_o
);

    mips_isa_pkg::opcode_e   opcode;
    mips_isa_pkg::funct_e    funct;
    logic [`MIPS_REG_AW-1:0] rd_addr;
    logic [4:0]              shamt;
    logic [15:0]             imm;
    logic [`MIPS_XLEN-1:0]   imm_sext;
    logic [`MIPS_XLEN-1:0]   rs_val;
    logic [`MIPS_XLEN-1:0]   rt_val;
    logic                    use_rs;
    logic                    use_rt;
    logic                    stall;
    mips_pipe_pkg::id_ex_t   nxt;

    // Execute beats memory beats the register file
    function automatic logic [`MIPS_XLEN-1:0] fwd_sel(
        input logic [`MIPS_REG_AW-1:0] addr,
        input logic [`MIPS_XLEN-1:0]   rf_data,
        input mips_pipe_pkg::fwd_t     ex_f,
        input mips_pipe_pkg::fwd_t     mem_f
    );
        if (addr == '0)
            return '0;
        if (ex_f.we && ex_f.addr == addr)
            return ex_f.data;
        if (mem_f.we && mem_f.addr == addr)
            return mem_f.data;
        return rf_data;
    endfunction

    assign opcode    = mips_isa_pkg::opcode_e'(if_id_i.inst[31:26]);
    assign funct     = mips_isa_pkg::funct_e'(if_id_i.inst[5:0]);
    assign rs_addr_o = if_id_i.inst[`MIPS_RS_LSB +: `MIPS_REG_AW];
    assign rt_addr_o = if_id_i.inst[`MIPS_RT_LSB +: `MIPS_REG_AW];
    assign rd_addr   = if_id_i.inst[`MIPS_RD_LSB +: `MIPS_REG_AW];
    assign shamt     = if_id_i.inst[`MIPS_SA_LSB +: 5];
    assign imm       = if_id_i.inst[15:0];
    assign imm_sext  = {{(`MIPS_XLEN-16){imm[15]}}, imm};
    assign rs_val    = fwd_sel(rs_addr_o, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val    = fwd_sel(rt_addr_o, rt_data_i, ex_fwd_i, mem_fwd_i);
    assign stall     = inst_stall_i | data_stall_i;

    // Target is relative to the delay slot
    assign branch_target_o = if_id_i.pc + `MIPS_XLEN'd4 + {imm_sext[`MIPS_XLEN-3:0], 2'b00};

    always_comb begin
        nxt            = '0;
        nxt.pc         = if_id_i.pc;
        nxt.alu_op     = mips_isa_pkg::ALU_ADD;
        nxt.op_a       = rs_val;
        nxt.op_b       = imm_sext;
        nxt.store_data = rt_val;
        nxt.dest       = rt_addr_o;
        use_rs         = 1'b1;
        use_rt         = 1'b0;
        branch_taken_o = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                use_rt     = 1'b1;
                nxt.reg_we = 1'b1;
                nxt.dest   = rd_addr;
                nxt.op_b   = rt_val;
                case (funct)
                    mips_isa_pkg::FN_SLL: begin
                        nxt.alu_op = mips_isa_pkg::ALU_SLL;
                        nxt.op_a   = rt_val;
                        nxt.op_b   = {{(`MIPS_XLEN-5){1'b0}}, shamt};
                        use_rs     = 1'b0;
                    end
                    mips_isa_pkg::FN_ADDU: nxt.alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: nxt.alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  nxt.alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   nxt.alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  nxt.alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  nxt.alu_op = mips_isa_pkg::ALU_SLT;
                    default:               nxt.reg_we = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: nxt.reg_we = 1'b1;
            mips_isa_pkg::OP_ORI: begin
                nxt.reg_we = 1'b1;
                nxt.alu_op = mips_isa_pkg::ALU_OR;
                nxt.op_b   = {{(`MIPS_XLEN-16){1'b0}}, imm};
            end
            mips_isa_pkg::OP_LUI: begin
                nxt.reg_we = 1'b1;
                nxt.alu_op = mips_isa_pkg::ALU_LUI;
                use_rs     = 1'b0;
            end
            mips_isa_pkg::OP_LW: begin
                nxt.reg_we   = 1'b1;
                nxt.mem_read = 1'b1;
            end
            mips_isa_pkg::OP_SW: begin
                nxt.mem_write = 1'b1;
                use_rt        = 1'b1;
            end
            mips_isa_pkg::OP_BEQ: begin
                use_rt         = 1'b1;
                branch_taken_o = rs_val == rt_val;
            end
            mips_isa_pkg::OP_BNE: begin
                use_rt         = 1'b1;
                branch_taken_o = rs_val != rt_val;
            end
            default: ;                      // Unknown opcode runs as a nop
        endcase
        if (nxt.dest == '0)
            nxt.reg_we = 1'b0;
    end

    assign load_use_stall_o = ex_mem_read_i && ex_fwd_i.addr != '0 &&
                              ((use_rs && ex_fwd_i.addr == rs_addr_o) ||
                               (use_rt && ex_fwd_i.addr == rt_addr_o));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            id_ex_o <= '0;
        else if (!stall)
            id_ex_o <= load_use_stall_o ? '0 : nxt;  // Bubble behind the load
    end

endmodule

// File: src/mips_execute.sv
`include "mips_consts.svh"

module mips_execute (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   inst_stall_i,
    input  logic                   data_stall_i,
    input  mips_pipe_pkg::id_ex_t  id_ex_i,
    output mips_pipe_pkg::fwd_t    ex_fwd_o,
    output logic                   ex_mem_read_o,
    output mips_pipe_pkg::ex_mem_t ex_mem_o
);

    logic [`MIPS_XLEN-1:0] result;

    always_comb begin
        case (id_ex_i.alu_op)
            mips_isa_pkg::ALU_ADD: result = id_ex_i.op_a + id_ex_i.op_b;
            mips_isa_pkg::ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
            mips_isa_pkg::ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
            mips_isa_pkg::ALU_OR:  result = id_ex_i.op_a | id_ex_i.op_b;
            mips_isa_pkg::ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
            mips_isa_pkg::ALU_SLT: begin
                result = {{(`MIPS_XLEN-1){1'b0}},
                          $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            end
            mips_isa_pkg::ALU_SLL: result = id_ex_i.op_a << id_ex_i.op_b[4:0];
            mips_isa_pkg::ALU_LUI: result = {id_ex_i.op_b[15:0], 16'h0000};
            default:               result = '0;
        endcase
    end

    // A load has no value yet, decode stalls on it instead
    assign ex_fwd_o.we   = id_ex_i.reg_we & ~id_ex_i.mem_read;
    assign ex_fwd_o.addr = id_ex_i.dest;
    assign ex_fwd_o.data = result;
    assign ex_mem_read_o = id_ex_i.mem_read;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else if (!(inst_stall_i | data_stall_i)) begin
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.alu_result <= result;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.dest       <= id_ex_i.dest;
            ex_mem_o.mem_read   <= id_ex_i.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.mem_write;
        end
    end

endmodule

// File: src/mips_memory.sv
`include "mips_consts.svh"

module mips_memory (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    inst_stall_i,
    input  logic                    data_stall_i,
    input  mips_pipe_pkg::ex_mem_t  ex_mem_i,
    output logic                    data_ren_o,
    output logic [3:0]              data_wen_o,
    output logic [`MIPS_XLEN-1:0]   data_addr_o,
    output logic [`MIPS_XLEN-1:0]   data_wdata_o,
    input  logic [`MIPS_XLEN-1:0]   data_rdata_i,
    output mips_pipe_pkg::fwd_t     mem_fwd_o,
    output mips_pipe_pkg::fwd_t     commit_o,
    output logic [`MIPS_XLEN-1:0]   wb_pc_o,
    output logic [3:0]              wb_wen_o,
    output logic [`MIPS_REG_AW-1:0] wb_num_o,
    output logic [`MIPS_XLEN-1:0]   wb_data_o
);

    logic                  stall;
    logic [`MIPS_XLEN-1:0] wb_value;
    mips_pipe_pkg::mem_wb_t mem_wb;

    assign stall        = inst_stall_i | data_stall_i;
    assign data_ren_o   = ex_mem_i.mem_read;
    assign data_wen_o   = (ex_mem_i.mem_write && !stall) ? 4'hF : 4'h0;  // Word stores only
    assign data_addr_o  = ex_mem_i.alu_result;
    assign data_wdata_o = ex_mem_i.store_data;
    assign wb_value     = ex_mem_i.mem_read ? data_rdata_i : ex_mem_i.alu_result;

    assign mem_fwd_o.we   = ex_mem_i.reg_we;
    assign mem_fwd_o.addr = ex_mem_i.dest;
    assign mem_fwd_o.data = wb_value;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb <= '0;
        end else if (!stall) begin
            mem_wb.pc     <= ex_mem_i.pc;
            mem_wb.reg_we <= ex_mem_i.reg_we;
            mem_wb.dest   <= ex_mem_i.dest;
            mem_wb.data   <= wb_value;
        end
    end

    // Retire on the edge that lets MEM/WB move on
    assign commit_o.we   = mem_wb.reg_we & ~stall;
    assign commit_o.addr = mem_wb.dest;
    assign commit_o.data = mem_wb.data;

    assign wb_pc_o   = commit_o.we ? mem_wb.pc : '0;
    assign wb_wen_o  = commit_o.we ? 4'hF : 4'h0;
    assign wb_num_o  = commit_o.we ? mem_wb.dest : '0;
    assign wb_data_o = commit_o.we ? mem_wb.data : '0;

endmodule

// File: src/mips_top.sv
`include "mips_consts.svh"

module mips_top (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    output logic [`MIPS_XLEN-1:0]   inst_sram_addr_o,
    input  logic [`MIPS_XLEN-1:0]   inst_sram_rdata_i,
    output logic                    data_sram_ren_o,
    output logic [3:0]              data_sram_wen_o,
    output logic [`MIPS_XLEN-1:0]   data_sram_addr_o,
    output logic [`MIPS_XLEN-1:0]   data_sram_wdata_o,
    input  logic [`MIPS_XLEN-1:0]   data_sram_rdata_i,
    input  logic                    inst_stall_i,
    input  logic                    data_stall_i,
    output logic [`MIPS_XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]              debug_wb_wen_o,
    output logic [`MIPS_REG_AW-1:0] debug_wb_num_o,
    output logic [`MIPS_XLEN-1:0]   debug_wb_data_o
);

    mips_pipe_pkg::if_id_t   if_id;
    mips_pipe_pkg::id_ex_t   id_ex;
    mips_pipe_pkg::ex_mem_t  ex_mem;
    mips_pipe_pkg::fwd_t     ex_fwd;
    mips_pipe_pkg::fwd_t     mem_fwd;
    mips_pipe_pkg::fwd_t     commit;
    logic [`MIPS_REG_AW-1:0] rs_addr;
    logic [`MIPS_REG_AW-1:0] rt_addr;
    logic [`MIPS_XLEN-1:0]   rs_data;
    logic [`MIPS_XLEN-1:0]   rt_data;
    logic [`MIPS_XLEN-1:0]   branch_target;
    logic                    branch_taken;
    logic                    load_use_stall;
    logic                    ex_mem_read;

    mips_fetch fetch_i (
        .clk_i, .arst_n_i, .inst_stall_i, .data_stall_i,
        .load_use_stall_i (load_use_stall),
        .branch_taken_i   (branch_taken),
        .branch_target_i  (branch_target),
        .inst_rdata_i     (inst_sram_rdata_i),
        .inst_addr_o      (inst_sram_addr_o),
        .if_id_o          (if_id)
    );

    mips_regfile regfile_i (
        .clk_i, .arst_n_i,
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .commit_i  (commit)
    );

    mips_decode decode_i (
        .clk_i, .arst_n_i, .inst_stall_i, .data_stall_i,
        .if_id_i          (if_id),
        .rs_addr_o        (rs_addr),
        .rt_addr_o        (rt_addr),
        .rs_data_i        (rs_data),
        .rt_data_i        (rt_data),
        .ex_fwd_i         (ex_fwd),
        .ex_mem_read_i    (ex_mem_read),
        .mem_fwd_i        (mem_fwd),
        .load_use_stall_o (load_use_stall),
        .branch_taken_o   (branch_taken),
        .branch_target_o  (branch_target),
        .id_ex_o          (id_ex)
    );

    mips_execute execute_i (
        .clk_i, .arst_n_i, .inst_stall_i, .data_stall_i,
        .id_ex_i       (id_ex),
        .ex_fwd_o      (ex_fwd),
        .ex_mem_read_o (ex_mem_read),
        .ex_mem_o      (ex_mem)
    );

    mips_memory memory_i (
        .clk_i, .arst_n_i, .inst_stall_i, .data_stall_i,
        .ex_mem_i     (ex_mem),
        .data_ren_o   (data_sram_ren_o),
        .data_wen_o   (data_sram_wen_o),
        .data_addr_o  (data_sram_addr_o),
        .data_wdata_o (data_sram_wdata_o),
        .data_rdata_i (data_sram_rdata_i),
        .mem_fwd_o    (mem_fwd),
        .commit_o     (commit),
        .wb_pc_o      (debug_wb_pc_o),
        .wb_wen_o     (debug_wb_wen_o),
        .wb_num_o     (debug_wb_num_o),
        .wb_data_o    (debug_wb_data_o)
    );

endmodule

// File: testbench/tb_mips_top.sv
`include "mips_consts.svh"

module tb_mips_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = 1000;

    bit                      clk;
    logic                    arst_n;
    logic [`MIPS_XLEN-1:0]   inst_sram_addr;
    logic [`MIPS_XLEN-1:0]   inst_sram_rdata;
    logic                    data_sram_ren;
    logic [3:0]              data_sram_wen;
    logic [`MIPS_XLEN-1:0]   data_sram_addr;
    logic [`MIPS_XLEN-1:0]   data_sram_wdata;
    logic [`MIPS_XLEN-1:0]   data_sram_rdata;
    logic                    inst_stall;
    logic                    data_stall;
    logic [`MIPS_XLEN-1:0]   debug_wb_pc;
    logic [3:0]              debug_wb_wen;
    logic [`MIPS_REG_AW-1:0] debug_wb_num;
    logic [`MIPS_XLEN-1:0]   debug_wb_data;

    logic [31:0] rom [NUM_WORDS];
    logic [31:0] ram [NUM_WORDS];
    int          exp_word[$];
    int          exp_reg[$];
    logic [31:0] exp_val[$];
    logic [31:0] store_addr;
    logic [31:0] store_data;
    int          retire_idx;
    int          store_count;
    int          load_count;
    int          seed;
    bit          stall_en;

    mips_top mips_top_i (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .inst_sram_addr_o  (inst_sram_addr),
        .inst_sram_rdata_i (inst_sram_rdata),
        .data_sram_ren_o   (data_sram_ren),
        .data_sram_wen_o   (data_sram_wen),
        .data_sram_addr_o  (data_sram_addr),
        .data_sram_wdata_o (data_sram_wdata),
        .data_sram_rdata_i (data_sram_rdata),
        .inst_stall_i      (inst_stall),
        .data_stall_i      (data_stall),
        .debug_wb_pc_o     (debug_wb_pc),
        .debug_wb_wen_o    (debug_wb_wen),
        .debug_wb_num_o    (debug_wb_num),
        .debug_wb_data_o   (debug_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] r_type(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] sa,
        input logic [5:0] funct
    );
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_type(
        input logic [5:0]  op,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    // Words outside the program window read as nops
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_PC;
        if (offset < 4 * NUM_WORDS)
            return rom[offset[7:2]];
        return 32'h0;
    endfunction

    task automatic note_retire(input int word, input int rd, input logic [31:0] value);
        exp_word.push_back(word);
        exp_reg.push_back(rd);
        exp_val.push_back(value);
    endtask

    task automatic load_program();
        for (int i = 0; i < NUM_WORDS; i++) begin
            rom[i] = 32'h0;
        end
        rom[0]  = i_type(6'h09, 0, 1, 16'h0005);     // addiu r1, r0, 5
        rom[1]  = i_type(6'h09, 1, 2, 16'hfffd);     // addiu r2, r1, -3
        rom[2]  = r_type(1, 2, 3, 0, 6'h21);         // addu r3, r1, r2
        rom[3]  = r_type(2, 3, 4, 0, 6'h23);         // subu r4, r2, r3
        rom[4]  = r_type(3, 4, 5, 0, 6'h24);         // and r5, r3, r4
        rom[5]  = r_type(5, 1, 6, 0, 6'h25);         // or r6, r5, r1
        rom[6]  = r_type(6, 4, 7, 0, 6'h26);         // xor r7, r6, r4
        rom[7]  = r_type(4, 1, 8, 0, 6'h2a);         // slt r8, r4, r1
        rom[8]  = r_type(0, 3, 9, 4, 6'h00);         // sll r9, r3, 4
        rom[9]  = i_type(6'h0f, 0, 10, 16'h1234);    // lui r10, 0x1234
        rom[10] = i_type(6'h0d, 10, 10, 16'h5678);   // ori r10, r10, 0x5678
        rom[11] = i_type(6'h09, 1, 0, 16'h0001);     // addiu r0, r1, 1
        rom[12] = i_type(6'h2b, 9, 10, 16'h0008);    // sw r10, 8(r9)
        rom[13] = i_type(6'h23, 9, 11, 16'h0008);    // lw r11, 8(r9)
        rom[14] = r_type(11, 1, 12, 0, 6'h21);       // addu r12, r11, r1
        rom[15] = i_type(6'h04, 12, 12, 16'h0002);   // beq r12, r12, +2
        rom[16] = i_type(6'h09, 0, 13, 16'h0011);    // Delay slot
        rom[17] = i_type(6'h09, 0, 14, 16'h0bad);    // Skipped by the branch
        rom[18] = i_type(6'h05, 1, 1, 16'h0005);     // bne r1, r1, not taken
        rom[19] = i_type(6'h09, 1, 15, 16'h0001);
        rom[20] = i_type(6'h09, 15, 16, 16'h0002);
        note_retire(0, 1, 32'h0000_0005);
        note_retire(1, 2, 32'h0000_0002);
        note_retire(2, 3, 32'h0000_0007);
        note_retire(3, 4, 32'hffff_fffb);
        note_retire(4, 5, 32'h0000_0003);
        note_retire(5, 6, 32'h0000_0007);
        note_retire(6, 7, 32'hffff_fffc);
        note_retire(7, 8, 32'h0000_0001);
        note_retire(8, 9, 32'h0000_0070);
        note_retire(9, 10, 32'h1234_0000);
        note_retire(10, 10, 32'h1234_5678);
        note_retire(13, 11, 32'h1234_5678);
        note_retire(14, 12, 32'h1234_567d);
        note_retire(16, 13, 32'h0000_0011);
        note_retire(19, 15, 32'h0000_0006);
        note_retire(20, 16, 32'h0000_0008);
        store_addr = 32'h0000_0078;
        store_data = 32'h1234_5678;
    endtask

    task automatic fill_data_ram();
        for (int i = 0; i < NUM_WORDS; i++) begin
            ram[i] = 32'hd0d0_0000 | (i * 4);
        end
    endtask

    task automatic check_reset_state();
        assert (inst_sram_addr == `MIPS_RESET_PC) else stop_on_error($sformatf(
            "Error: inst_sram_addr_o = %h, expected %h", inst_sram_addr, `MIPS_RESET_PC));
        assert (data_sram_ren == 1'b0) else stop_on_error($sformatf(
            "Error: data_sram_ren_o = %h, expected %h", data_sram_ren, 1'b0));
        assert (data_sram_wen == 4'h0) else stop_on_error($sformatf(
            "Error: data_sram_wen_o = %h, expected %h", data_sram_wen, 4'h0));
        assert (debug_wb_wen == 4'h0) else stop_on_error($sformatf(
            "Error: debug_wb_wen_o = %h, expected %h", debug_wb_wen, 4'h0));
    endtask

    task automatic check_retirement();
        logic [31:0] pc_exp;
        if (retire_idx >= exp_word.size()) begin
            stop_on_error("An instruction retired after the last expected one");
        end else begin
            pc_exp = `MIPS_RESET_PC + 4 * exp_word[retire_idx];
            assert (debug_wb_wen == 4'hf) else stop_on_error($sformatf(
                "Error: debug_wb_wen_o = %h, expected %h", debug_wb_wen, 4'hf));
            assert (debug_wb_pc == pc_exp) else stop_on_error($sformatf(
                "Error: debug_wb_pc_o = %h, expected %h", debug_wb_pc, pc_exp));
            assert (debug_wb_num == exp_reg[retire_idx]) else stop_on_error($sformatf(
                "Error: debug_wb_num_o = %h, expected %h", debug_wb_num, exp_reg[retire_idx]));
            assert (debug_wb_data == exp_val[retire_idx]) else stop_on_error($sformatf(
                "Error: debug_wb_data_o = %h, expected %h", debug_wb_data, exp_val[retire_idx]));
            retire_idx++;
        end
    endtask

    // SRAM read data and stall levels, driven mid-cycle
    always @(negedge clk) begin
        inst_sram_rdata <= rom_word(inst_sram_addr);
        data_sram_rdata <= ram[data_sram_addr[7:2]];
        if (stall_en) begin
            inst_stall <= ($random(seed) & 3) == 0;
            data_stall <= ($random(seed) & 3) == 0;
        end else begin
            inst_stall <= 1'b0;
            data_stall <= 1'b0;
        end
    end

    // What the DUT commits on this edge
    always @(posedge clk) begin
        if (arst_n) begin
            if (inst_stall || data_stall) begin
                assert (debug_wb_wen == 4'h0) else stop_on_error($sformatf(
                    "Error: debug_wb_wen_o = %h while stalled, expected %h", debug_wb_wen, 4'h0));
                assert (data_sram_wen == 4'h0) else stop_on_error($sformatf(
                    "Error: data_sram_wen_o = %h while stalled, expected %h", data_sram_wen, 4'h0));
            end
            if (data_sram_ren) begin
                assert (data_sram_addr == store_addr) else stop_on_error($sformatf(
                    "Error: data_sram_addr_o = %h on a read, expected %h",
                    data_sram_addr, store_addr));
                if (!inst_stall && !data_stall)
                    load_count++;
            end
            if (data_sram_wen != 4'h0) begin
                assert (data_sram_wen == 4'hf) else stop_on_error($sformatf(
                    "Error: data_sram_wen_o = %h, expected %h", data_sram_wen, 4'hf));
                assert (data_sram_addr == store_addr) else stop_on_error($sformatf(
                    "Error: data_sram_addr_o = %h, expected %h", data_sram_addr, store_addr));
                assert (data_sram_wdata == store_data) else stop_on_error($sformatf(
                    "Error: data_sram_wdata_o = %h, expected %h", data_sram_wdata, store_data));
                ram[data_sram_addr[7:2]] <= data_sram_wdata;
                store_count++;
            end
            if (debug_wb_wen != 4'h0)
                check_retirement();
        end
    end

    task automatic run_program(input bit with_stalls);
        int cycles;
        stall_en = with_stalls;
        @(negedge clk);
        arst_n      = 1'b0;
        retire_idx  = 0;
        store_count = 0;
        load_count  = 0;
        fill_data_ram();
        repeat (16) begin
            @(posedge clk);
            check_reset_state();
        end
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        check_reset_state();                          // First cycle out of reset
        cycles = 0;
        while (retire_idx < exp_word.size() && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_idx < exp_word.size()) begin
            stop_on_error("Timed out waiting for the program to retire");
        end else begin
            repeat (20) @(negedge clk);               // Window for stray retirements
            assert (store_count == 1) else stop_on_error($sformatf(
                "Error: store count = %h, expected %h", store_count, 1));
            assert (load_count == 1) else stop_on_error($sformatf(
                "Error: load count = %h, expected %h", load_count, 1));
        end
    endtask

    initial begin
        arst_n          = 1'b0;
        inst_stall      = 1'b0;
        data_stall      = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        stall_en        = 1'b0;
        seed            = 59452;
        load_program();
        run_program(1'b0);
        run_program(1'b1);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/mips_fetch.sv
src/mips_regfile.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_memory.sv
src/mips_top.sv
testbench/tb_mips_top.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - files:
      - src/mips_isa_pkg.sv
      - src/mips_pipe_pkg.sv
      - src/mips_fetch.sv
      - src/mips_regfile.sv
      - src/mips_decode.sv
      - src/mips_execute.sv
      - src/mips_memory.sv
      - src/mips_top.sv
  - target: test
    files:
      - testbench/tb_mips_top.sv
